// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

   typedef logic [31:0] word_t;      // data and address word
   typedef logic [4:0]  reg_addr_t;  // register index

   localparam word_t     RESET_PC   = 32'h0040_0000;
   localparam reg_addr_t LINK_REG   = 5'd31;  // jal destination
   localparam int        DMEM_WORDS = 2048;

   // instruction field positions (lsb of each field)
   localparam int OP_LSB = 26;
   localparam int RS_LSB = 21;
   localparam int RT_LSB = 16;
   localparam int RD_LSB = 11;
   localparam int SH_LSB = 6;
   localparam int FN_LSB = 0;

   //////////////////////////////////////////////////////////////////////
   // primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_JAL   = 6'h03;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_SLTI  = 6'h0a;
   localparam logic [5:0] OP_SLTIU = 6'h0b;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_XORI  = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   //////////////////////////////////////////////////////////////////////
   // function codes, valid with OP_RTYPE
   localparam logic [5:0] FN_SLL  = 6'h00;
   localparam logic [5:0] FN_SRL  = 6'h02;
   localparam logic [5:0] FN_SRA  = 6'h03;
   localparam logic [5:0] FN_JR   = 6'h08;
   localparam logic [5:0] FN_ADD  = 6'h20;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUB  = 6'h22;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;
   localparam logic [5:0] FN_SLT  = 6'h2a;
   localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

   // alu function select
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_NOR  = 4'd5,
      ALU_SLT  = 4'd6,
      ALU_SLTU = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_LUI  = 4'd11
   } alu_op_t;

   // register write-back source
   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_MEM  = 2'd1,
      WB_LINK = 2'd2   // return address for jal
   } wb_sel_t;

   // destination register field
   typedef enum logic [1:0] {
      DST_RD   = 2'd0,
      DST_RT   = 2'd1,
      DST_LINK = 2'd2
   } dst_sel_t;

   // next pc source
   typedef enum logic [1:0] {
      PC_SEQ    = 2'd0,
      PC_BRANCH = 2'd1,
      PC_JUMP   = 2'd2,
      PC_REG    = 2'd3
   } pc_sel_t;

endpackage

`default_nettype wire

// File: source/ctrl_decode.sv
`default_nettype none
`timescale 1ns/1ps

module ctrl_decode (
   input  logic [5:0]          opcode,
   input  logic [5:0]          funct,
   input  logic                zero,
   output core_pkg::alu_op_t   alu_op,
   output logic                alu_src_imm,
   output logic                sign_ext,
   output logic                shift_imm,
   output core_pkg::dst_sel_t  dst_sel,
   output core_pkg::wb_sel_t   wb_sel,
   output logic                reg_write,
   output logic                mem_write,
   output core_pkg::pc_sel_t   pc_sel
);
   import isa_pkg::*;
   import core_pkg::*;

   always_comb begin
      // defaults give a no-op
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b0;
      sign_ext    = 1'b1;
      shift_imm   = 1'b0;
      dst_sel     = DST_RD;
      wb_sel      = WB_ALU;
      reg_write   = 1'b0;
      mem_write   = 1'b0;
      pc_sel      = PC_SEQ;

      case (opcode)
         OP_RTYPE: begin
            reg_write = 1'b1;
            case (funct)
               FN_ADD, FN_ADDU: alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: alu_op = ALU_SUB;
               FN_AND:          alu_op = ALU_AND;
               FN_OR:           alu_op = ALU_OR;
               FN_XOR:          alu_op = ALU_XOR;
               FN_NOR:          alu_op = ALU_NOR;
               FN_SLT:          alu_op = ALU_SLT;
               FN_SLTU:         alu_op = ALU_SLTU;
               FN_SLL, FN_SRL, FN_SRA: begin
                  shift_imm = 1'b1;  // amount from shamt field
                  if (funct == FN_SLL)
                     alu_op = ALU_SLL;
                  else if (funct == FN_SRL)
                     alu_op = ALU_SRL;
                  else
                     alu_op = ALU_SRA;
               end
               FN_JR: begin
                  reg_write = 1'b0;
                  pc_sel    = PC_REG;
               end
               default:         reg_write = 1'b0;  // unknown funct
            endcase
         end

         OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            alu_src_imm = 1'b1;
            dst_sel     = DST_RT;
            reg_write   = 1'b1;
            sign_ext    = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI});  // logic ops zero-extend
            case (opcode)
               OP_SLTI:  alu_op = ALU_SLT;
               OP_SLTIU: alu_op = ALU_SLTU;
               OP_ANDI:  alu_op = ALU_AND;
               OP_ORI:   alu_op = ALU_OR;
               OP_XORI:  alu_op = ALU_XOR;
               OP_LUI:   alu_op = ALU_LUI;
               default:  alu_op = ALU_ADD;
            endcase
         end

         OP_LW: begin
            alu_src_imm = 1'b1;
            dst_sel     = DST_RT;
            wb_sel      = WB_MEM;
            reg_write   = 1'b1;
         end
         OP_SW: begin
            alu_src_imm = 1'b1;  // base + offset
            mem_write   = 1'b1;
         end

         OP_BEQ, OP_BNE: begin
            alu_op = ALU_SUB;  // compare rs with rt
            if (zero == (opcode == OP_BEQ))
               pc_sel = PC_BRANCH;
         end

         OP_J:   pc_sel = PC_JUMP;
         OP_JAL: begin
            pc_sel    = PC_JUMP;
            dst_sel   = DST_LINK;
            wb_sel    = WB_LINK;
            reg_write = 1'b1;
         end

         default: ;  // unknown opcode stays a no-op
      endcase
   end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
   input  isa_pkg::word_t     a,
   input  isa_pkg::word_t     b,
   input  core_pkg::alu_op_t  alu_op,
   output isa_pkg::word_t     result,
   output logic               zero
);
   import core_pkg::*;

   logic [4:0] sh_amt;

   assign sh_amt = a[4:0];  // shifts use low five bits only

   always_comb begin
      case (alu_op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
         ALU_SLTU: result = {31'd0, a < b};
         ALU_SLL:  result = b << sh_amt;
         ALU_SRL:  result = b >> sh_amt;
         ALU_SRA:  result = $signed(b) >>> sh_amt;  // sign fill
         ALU_LUI:  result = {b[15:0], 16'h0000};
         default:  result = a + b;
      endcase
   end

   // branch compare relies on this after ALU_SUB
   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  logic               we,
   input  isa_pkg::reg_addr_t raddr1,
   input  isa_pkg::reg_addr_t raddr2,
   input  isa_pkg::reg_addr_t waddr,
   input  isa_pkg::word_t     wdata,
   output isa_pkg::word_t     rdata1,
   output isa_pkg::word_t     rdata2
);
   import isa_pkg::*;

   word_t regs [1:31];  // no storage behind r0

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // combinational read, r0 hard-wired to zero
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
   assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/data_mem.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem (
   input  logic           clk,
   input  logic           write,
   input  isa_pkg::word_t addr,
   input  isa_pkg::word_t wdata,
   output isa_pkg::word_t rdata
);
   import isa_pkg::*;

   localparam int AW = $clog2(DMEM_WORDS);

   word_t          mem [DMEM_WORDS];
   logic [AW-1:0]  word_idx;

   assign word_idx = addr[AW+1:2];  // drop byte offset

   always_ff @(posedge clk) begin
      if (write)
         mem[word_idx] <= wdata;
   end

   assign rdata = mem[word_idx];  // same-cycle load data

endmodule

`default_nettype wire

// File: source/mips_core.sv
`default_nettype none
`timescale 1ns/1ps

module mips_core (
   input  logic           clk,
   input  logic           rst,
   input  isa_pkg::word_t instr,
   output isa_pkg::word_t pc,
   input  isa_pkg::word_t mem_rdata,
   output logic           mem_write,
   output isa_pkg::word_t mem_addr,
   output isa_pkg::word_t mem_wdata
);
   import isa_pkg::*;
   import core_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   logic [4:0] shamt;
   logic [15:0] imm16;
   reg_addr_t  rs_addr, rt_addr, rd_addr, wr_addr;
   word_t      rs_data, rt_data, wb_data;
   word_t      imm_ext, br_off, alu_a, alu_b, alu_result;
   word_t      pc_plus4, pc_plus8, br_target, jmp_target, next_pc;
   logic       zero, alu_src_imm, sign_ext, shift_imm, reg_write, store_dec;
   alu_op_t    alu_op;
   dst_sel_t   dst_sel;
   wb_sel_t    wb_sel;
   pc_sel_t    pc_sel;

   assign opcode  = instr[OP_LSB +: 6];
   assign funct   = instr[FN_LSB +: 6];
   assign rs_addr = instr[RS_LSB +: 5];
   assign rt_addr = instr[RT_LSB +: 5];
   assign rd_addr = instr[RD_LSB +: 5];
   assign shamt   = instr[SH_LSB +: 5];
   assign imm16   = instr[15:0];

   ////////////////////////////////////////////////////////////////////
   // program counter and next-pc selection

   assign pc_plus4   = pc + 32'd4;
   assign pc_plus8   = pc + 32'd8;  // jal link value
   assign br_off     = {{14{imm16[15]}}, imm16, 2'b00};
   assign br_target  = pc_plus4 + br_off;
   assign jmp_target = {pc_plus4[31:28], instr[25:0], 2'b00};

   always_comb begin
      case (pc_sel)
         PC_BRANCH: next_pc = br_target;
         PC_JUMP:   next_pc = jmp_target;
         PC_REG:    next_pc = rs_data;  // jr
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         pc <= RESET_PC;
      else
         pc <= next_pc;
   end

   ////////////////////////////////////////////////////////////////////
   // operands and write-back

   assign imm_ext = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
   assign alu_a   = shift_imm ? {27'd0, shamt} : rs_data;
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;

   always_comb begin
      case (dst_sel)
         DST_RT:   wr_addr = rt_addr;
         DST_LINK: wr_addr = LINK_REG;
         default:  wr_addr = rd_addr;
      endcase
      case (wb_sel)
         WB_MEM:  wb_data = mem_rdata;
         WB_LINK: wb_data = pc_plus8;
         default: wb_data = alu_result;
      endcase
   end

   assign mem_addr  = alu_result;  // base + offset
   assign mem_wdata = rt_data;
   assign mem_write = store_dec & ~rst;  // held off during reset

   ctrl_decode u_ctrl (
      .opcode      (opcode),
      .funct       (funct),
      .zero        (zero),
      .alu_op      (alu_op),
      .alu_src_imm (alu_src_imm),
      .sign_ext    (sign_ext),
      .shift_imm   (shift_imm),
      .dst_sel     (dst_sel),
      .wb_sel      (wb_sel),
      .reg_write   (reg_write),
      .mem_write   (store_dec),
      .pc_sel      (pc_sel)
   );

   alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .alu_op (alu_op),
      .result (alu_result),
      .zero   (zero)
   );

   reg_file u_rf (
      .clk    (clk),
      .rst    (rst),
      .we     (reg_write),
      .raddr1 (rs_addr),
      .raddr2 (rt_addr),
      .waddr  (wr_addr),
      .wdata  (wb_data),
      .rdata1 (rs_data),
      .rdata2 (rt_data)
   );

endmodule

`default_nettype wire

// File: source/sc_cpu.sv
`default_nettype none
`timescale 1ns/1ps

module sc_cpu (
   input  logic           clk,
   input  logic           rst,
   input  isa_pkg::word_t instr,
   output isa_pkg::word_t pc,
   output logic           mem_write,
   output isa_pkg::word_t mem_addr,
   output isa_pkg::word_t mem_wdata
);
   import isa_pkg::*;

   word_t mem_rdata;  // load data back to core

   mips_core u_core (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .pc        (pc),
      .mem_rdata (mem_rdata),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata)
   );

   data_mem u_dmem (
      .clk   (clk),
      .write (mem_write),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// File: bench/tb_sc_cpu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_sc_cpu;
   import isa_pkg::*;

   localparam int    ROM_WORDS    = 64;
   localparam word_t NOP          = 32'h0000_0000;  // sll r0, r0, 0
   localparam int    RESET_CYCLES = 4;
   localparam int    N_RESETS     = 5;
   localparam int    RUN_FIRST    = 1;
   localparam int    RUN_ALU      = 48;
   localparam int    RUN_LOAD     = 8;
   localparam int    RUN_BRANCH   = 16;
   localparam int    RUN_JUMP     = 10;
   localparam int    RUN_TOTAL    = RUN_FIRST + RUN_ALU + RUN_LOAD + RUN_BRANCH + RUN_JUMP
                                    + N_RESETS * RESET_CYCLES;
   localparam int    CYCLE_LIMIT  = RUN_TOTAL + RUN_TOTAL / 5;

   logic  clk;
   logic  rst;
   word_t instr;
   word_t pc;
   logic  mem_write;
   word_t mem_addr;
   word_t mem_wdata;

   word_t rom [0:ROM_WORDS-1];
   word_t rom_idx;
   int    prog_len;
   word_t lcg_state = 32'h7cdb_81ee;
   int    value_errors = 0;
   int    other_errors = 0;
   int    cycle_count = 0;

   word_t pc_trace [$];   // pc of every executed cycle
   word_t st_addr [$];
   word_t st_data [$];
   word_t exp_addr [$];
   word_t exp_data [$];
   int    exp_path [$];   // expected rom indices

   sc_cpu DUT (
      .clk       (clk),
      .rst       (rst),
      .instr     (instr),
      .pc        (pc),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata)
   );

   // combinational instruction rom, nop outside the program
   assign rom_idx = (pc - RESET_PC) >> 2;
   assign instr   = (rom_idx < ROM_WORDS) ? rom[rom_idx[5:0]] : NOP;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // encoding and reference arithmetic

   function automatic word_t next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t rtype_word(input logic [5:0] fn, input reg_addr_t rs,
                                        input reg_addr_t rt, input reg_addr_t rd,
                                        input logic [4:0] sh);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                        input reg_addr_t rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t jump_word(input logic [5:0] op, input word_t target);
      return {op, target[27:2]};  // region bits come from pc + 4
   endfunction

   function automatic word_t rop_expect(input logic [5:0] fn, input word_t a, input word_t b,
                                        input logic [4:0] sh);
      word_t r;
      case (fn)
         FN_ADD, FN_ADDU: r = a + b;
         FN_SUB, FN_SUBU: r = a - b;
         FN_AND:          r = a & b;
         FN_OR:           r = a | b;
         FN_XOR:          r = a ^ b;
         FN_NOR:          r = ~(a | b);
         FN_SLT:          r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
         FN_SLTU:         r = {31'd0, a < b};
         FN_SLL:          r = b << sh;
         FN_SRL:          r = b >> sh;
         FN_SRA:          r = b[31] ? ~(~b >> sh) : (b >> sh);  // ones shifted in
         default:         r = '0;
      endcase
      return r;
   endfunction

   function automatic word_t iop_expect(input logic [5:0] op, input word_t a,
                                        input logic [15:0] imm);
      word_t se;
      word_t ze;
      word_t r;
      se = {{16{imm[15]}}, imm};
      ze = {16'h0000, imm};
      case (op)
         OP_ADDI, OP_ADDIU: r = a + se;
         OP_SLTI:           r = (a[31] != se[31]) ? {31'd0, a[31]} : {31'd0, a < se};
         OP_SLTIU:          r = {31'd0, a < se};  // unsigned against sign-extended imm
         OP_ANDI:           r = a & ze;
         OP_ORI:            r = a | ze;
         OP_XORI:           r = a ^ ze;
         OP_LUI:            r = {imm, 16'h0000};
         default:           r = '0;
      endcase
      return r;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // program assembly

   task automatic clear_program();
      foreach (rom[i])
         rom[i] = NOP;
      prog_len = 0;
      exp_addr.delete();
      exp_data.delete();
      exp_path.delete();
   endtask

   task automatic emit(input word_t w);
      rom[prog_len[5:0]] = w;
      prog_len++;
   endtask

   task automatic load_word(input reg_addr_t r, input word_t value);
      emit(itype_word(OP_LUI, 5'd0, r, value[31:16]));
      emit(itype_word(OP_ORI, r, r, value[15:0]));
   endtask

   task automatic branch_to(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                            input int to_idx);
      emit(itype_word(op, rs, rt, 16'(to_idx - prog_len - 1)));  // offset from pc + 4
   endtask

   task automatic jump_to(input logic [5:0] op, input int to_idx);
      emit(jump_word(op, RESET_PC + 32'(4 * to_idx)));
   endtask

   task automatic expect_store(input word_t addr, input word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // sw r3 into result slot, base r0
   task automatic store_result(input int slot, input word_t value);
      logic [15:0] off;
      off = 16'h0100 + 16'(4 * slot);
      emit(itype_word(OP_SW, 5'd0, 5'd3, off));
      expect_store({16'h0000, off}, value);
   endtask

   //////////////////////////////////////////////////////////////////////
   // compare tasks

   task automatic check_word(input word_t actual, input word_t expected, input string what);
      if (actual !== expected) begin
         $display("Fail %0t: %s got %h expected %h", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   task automatic check_pc(input word_t actual, input word_t expected, input string what);
      if (actual !== expected) begin
         $display("Fail %0t: %s pc %h expected %h", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         $display("Fail %0t: %s got %b expected %b", $time, what, actual, expected);
         value_errors++;
      end
   endtask

   task automatic check_stores(input string tag);
      int n;
      n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
      if (st_addr.size() < exp_addr.size()) begin
         $display("%s: missing store, expected %0d stores but the DUT made %0d",
                  tag, exp_addr.size(), st_addr.size());
         other_errors++;
      end else if (st_addr.size() > exp_addr.size()) begin
         $display("%s: unexpected store, expected %0d stores but the DUT made %0d",
                  tag, exp_addr.size(), st_addr.size());
         other_errors++;
      end
      for (int i = 0; i < n; i++) begin
         check_word(st_addr[i], exp_addr[i], $sformatf("%s store %0d address", tag, i));
         check_word(st_data[i], exp_data[i], $sformatf("%s store %0d data", tag, i));
      end
   endtask

   task automatic check_trace(input string tag);
      foreach (exp_path[i])
         check_pc(pc_trace[i], RESET_PC + 32'(4 * exp_path[i]),
                  $sformatf("%s step %0d", tag, i));
   endtask

   //////////////////////////////////////////////////////////////////////
   // reset and stepping

   task automatic reset_dut();
      @(posedge clk);
      rst <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_pc(pc, RESET_PC, "during reset");
      end
      @(posedge clk);
      rst <= 1'b0;
   endtask

   // sample mid-cycle, one instruction per cycle
   task automatic run_program(input int n);
      pc_trace.delete();
      st_addr.delete();
      st_data.delete();
      repeat (n) begin
         @(negedge clk);
         pc_trace.push_back(pc);
         if (mem_write) begin
            st_addr.push_back(mem_addr);
            st_data.push_back(mem_wdata);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic reset_values();
      clear_program();
      emit(itype_word(OP_SW, 5'd0, 5'd0, 16'h0600));  // store waiting at the reset pc
      @(posedge clk);
      rst <= 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_pc(pc, RESET_PC, "during reset");
         check_flag(mem_write, 1'b0, "mem_write during reset");
      end
      rom[0] = itype_word(OP_LUI, 5'd0, 5'd1, 16'h1234);
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_pc(pc, RESET_PC, "first cycle after reset");
      check_flag(mem_write, 1'b0, "mem_write in first cycle");
   endtask

   task automatic alu_ops();
      logic [5:0]  rfn [10];
      logic [5:0]  sfn [3];
      logic [5:0]  iop [8];
      word_t       a;
      word_t       b;
      word_t       rnd;
      logic [4:0]  sh;
      logic [15:0] imm;
      int          slot;
      rfn = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
              FN_SLT, FN_SLTU};
      sfn = '{FN_SLL, FN_SRL, FN_SRA};
      iop = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      clear_program();
      a = next_random();
      b = next_random();
      load_word(5'd1, a);
      load_word(5'd2, b);
      slot = 0;
      foreach (rfn[i]) begin
         emit(rtype_word(rfn[i], 5'd1, 5'd2, 5'd3, 5'd0));
         store_result(slot, rop_expect(rfn[i], a, b, 5'd0));
         slot++;
      end
      foreach (sfn[i]) begin
         rnd = next_random();
         sh  = rnd[4:0];
         emit(rtype_word(sfn[i], 5'd0, 5'd2, 5'd3, sh));
         store_result(slot, rop_expect(sfn[i], a, b, sh));
         slot++;
      end
      foreach (iop[i]) begin
         rnd = next_random();
         imm = rnd[15:0];
         emit(itype_word(iop[i], 5'd1, 5'd3, imm));
         store_result(slot, iop_expect(iop[i], a, imm));
         slot++;
      end
      reset_dut();
      run_program(RUN_ALU);
      check_stores("alu");
   endtask

   task automatic load_round_trip();
      word_t w;
      w = next_random();
      clear_program();
      load_word(5'd1, w);
      emit(itype_word(OP_ORI, 5'd0, 5'd6, 16'h0300));  // base 0x300
      emit(itype_word(OP_SW, 5'd6, 5'd1, 16'hfffc));   // negative offset
      emit(itype_word(OP_LW, 5'd6, 5'd5, 16'hfffc));
      emit(itype_word(OP_SW, 5'd0, 5'd5, 16'h0204));
      expect_store(32'h0000_02fc, w);
      expect_store(32'h0000_0204, w);
      reset_dut();
      run_program(RUN_LOAD);
      check_stores("load");
   endtask

   task automatic branch_paths();
      int path [16];
      path = '{0, 1, 2, 3, 5, 7, 8, 9, 10, 11, 14, 12, 13, 16, 17, 18};
      clear_program();
      emit(itype_word(OP_ORI, 5'd0, 5'd1, 16'd5));
      emit(itype_word(OP_ORI, 5'd0, 5'd2, 16'd5));
      emit(itype_word(OP_ORI, 5'd0, 5'd3, 16'd7));
      branch_to(OP_BEQ, 5'd1, 5'd2, 5);                 // taken
      emit(itype_word(OP_SW, 5'd0, 5'd1, 16'h0400));    // skipped
      branch_to(OP_BNE, 5'd1, 5'd3, 7);                 // taken
      emit(itype_word(OP_SW, 5'd0, 5'd1, 16'h0404));    // skipped
      branch_to(OP_BEQ, 5'd1, 5'd3, 10);                // not taken
      emit(itype_word(OP_SW, 5'd0, 5'd2, 16'h0408));
      branch_to(OP_BNE, 5'd1, 5'd2, 11);                // not taken
      emit(itype_word(OP_SW, 5'd0, 5'd3, 16'h040c));
      branch_to(OP_BEQ, 5'd0, 5'd0, 14);
      emit(itype_word(OP_SW, 5'd0, 5'd2, 16'h0414));    // reached backwards
      branch_to(OP_BEQ, 5'd0, 5'd0, 16);
      branch_to(OP_BEQ, 5'd0, 5'd0, 12);                // backward branch
      emit(itype_word(OP_SW, 5'd0, 5'd1, 16'h0418));    // never reached
      expect_store(32'h0000_0408, 32'd5);
      expect_store(32'h0000_040c, 32'd7);
      expect_store(32'h0000_0414, 32'd5);
      foreach (path[i])
         exp_path.push_back(path[i]);
      reset_dut();
      run_program(RUN_BRANCH);
      check_trace("branch");
      check_stores("branch");
   endtask

   task automatic jump_paths();
      int    path [10];
      word_t link;
      path = '{0, 1, 4, 8, 9, 6, 7, 12, 13, 14};
      link = RESET_PC + 32'(4 * 4) + 32'd8;  // jal sits at index 4
      clear_program();
      emit(itype_word(OP_ORI, 5'd0, 5'd1, 16'h0055));
      jump_to(OP_J, 4);
      emit(itype_word(OP_SW, 5'd0, 5'd1, 16'h0500));    // skipped
      emit(NOP);
      jump_to(OP_JAL, 8);
      emit(itype_word(OP_SW, 5'd0, 5'd1, 16'h0504));    // skipped, return lands past it
      emit(itype_word(OP_SW, 5'd0, LINK_REG, 16'h0508));
      jump_to(OP_J, 12);
      emit(itype_word(OP_SW, 5'd0, LINK_REG, 16'h050c));
      emit(rtype_word(FN_JR, LINK_REG, 5'd0, 5'd0, 5'd0));
      expect_store(32'h0000_050c, link);
      expect_store(32'h0000_0508, link);
      foreach (path[i])
         exp_path.push_back(path[i]);
      reset_dut();
      run_program(RUN_JUMP);
      check_trace("jump");
      check_stores("jump");
   endtask

   //////////////////////////////////////////////////////////////////////
   // sequence and verdict

   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rst = 1'b1;
      reset_values();
      alu_ops();
      load_round_trip();
      branch_paths();
      jump_paths();
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
source/isa_pkg.sv
source/core_pkg.sv
source/ctrl_decode.sv
source/alu.sv
source/reg_file.sv
source/data_mem.sv
source/mips_core.sv
source/sc_cpu.sv
bench/tb_sc_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_sc_cpu -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx '>>> PASS'; then
   exit 0
else
   exit 1
fi
